// ==== filelist.f ====
+incdir+logic
logic/tone_pkg.sv
logic/tone_cfg_if.sv
logic/lb_regmap.sv
logic/dlo.sv
logic/tone_sum.sv
logic/tone_synth_top.sv
tb/tone_synth_checks.sv
tb/tone_synth_tb.sv

// ==== logic/dlo.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module dlo (
	input logic dsp,
	input logic rst_n,
	input logic phase_clr,
	input logic [`PHASE_W-1:0] freq,
	input logic signed [`SAMPLE_W-1:0] amp,
	output logic signed [`SAMPLE_W-1:0] x,
	output logic signed [`SAMPLE_W-1:0] y
);

	logic [`PHASE_W-1:0] phase;
	logic [`LUT_BITS-1:0] idx_cos;
	logic [`LUT_BITS-1:0] idx_sin;
	logic signed [`SAMPLE_W-1:0] cos_q;
	logic signed [`SAMPLE_W-1:0] sin_q;
	logic signed [`SAMPLE_W-1:0] amp_q;
	logic signed [2*`SAMPLE_W-1:0] prod_x;
	logic signed [2*`SAMPLE_W-1:0] prod_y;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase accumulator
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge dsp) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (phase_clr) begin
			phase <= '0;
		end else begin
			phase <= phase + freq;
		end
	end

	// sine lags cosine by a quarter turn of the table
	assign idx_cos = phase[`PHASE_W-1 -: `LUT_BITS];
	assign idx_sin = idx_cos - tone_pkg::QUARTER[`LUT_BITS-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, table lookup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// amp travels with the lookup so both factors belong to the same phase
	always_ff @(posedge dsp) begin
		cos_q <= tone_pkg::cos_entry(idx_cos);
		sin_q <= tone_pkg::cos_entry(idx_sin);
		amp_q <= amp;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, amplitude scaling
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign prod_x = amp_q * cos_q;
	assign prod_y = amp_q * sin_q;

	// taking bits 30 down to 15 is the arithmetic shift right by 15
	always_ff @(posedge dsp) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else begin
			x <= prod_x[2*`SAMPLE_W-2 -: `SAMPLE_W];
			y <= prod_y[2*`SAMPLE_W-2 -: `SAMPLE_W];
		end
	end

	// a restart lands on phase zero no matter what freq was
	a_phase_restart: assert property (@(posedge dsp) disable iff (!rst_n)
		phase_clr |=> (phase == '0));

endmodule

// ==== logic/lb_regmap.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module lb_regmap (
	input logic dsp,
	input logic rst_n,
	input tone_pkg::lb_op_e lb_op,
	input logic [`ADDR_W-1:0] lb_addr,
	input logic [31:0] lb_wdata,
	output logic [31:0] lb_rdata,
	output logic lb_rvalid,
	tone_cfg_if.regmap cfg
);

	localparam int IDX_W = $clog2(`TONE_COUNT);

	logic [`PHASE_W-1:0] freq_r [`TONE_COUNT];
	logic signed [`SAMPLE_W-1:0] amp_r [`TONE_COUNT];
	logic [31:0] scratch;
	logic [`TONE_PAIRS-1:0] phase_clr_r;
	logic [`TONE_PAIRS-1:0] freq_wr_pair;
	logic [31:0] rd_mux;
	logic wr_en;
	logic is_tone;
	logic is_scratch;
	logic [IDX_W-1:0] tone_idx;
	tone_pkg::reg_field_e field;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wr_en = (lb_op == tone_pkg::LB_WRITE);
	assign is_tone = (lb_addr < `ADDR_W'(2 * `TONE_COUNT));
	assign is_scratch = (lb_addr == `ADDR_W'(`ADDR_SCRATCH));
	assign tone_idx = lb_addr[IDX_W:1];
	assign field = tone_pkg::reg_field_e'(lb_addr[0]);

	// a frequency write restarts every oscillator of the pair it belongs to
	always_comb begin
		freq_wr_pair = '0;
		if (wr_en && is_tone && field == tone_pkg::FIELD_FREQ) begin
			freq_wr_pair[tone_idx / `TONES_PER_PAIR] = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// configuration registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge dsp) begin
		if (!rst_n) begin
			for (int i = 0; i < `TONE_COUNT; i++) begin
				freq_r[i] <= '0;
				amp_r[i] <= '0;
			end
			scratch <= '0;
			phase_clr_r <= '0;
		end else begin
			phase_clr_r <= freq_wr_pair;
			if (wr_en && is_tone) begin
				if (field == tone_pkg::FIELD_FREQ) begin
					freq_r[tone_idx] <= lb_wdata;
				end else begin
					amp_r[tone_idx] <= lb_wdata[`SAMPLE_W-1:0];
				end
			end
			if (wr_en && is_scratch) begin
				scratch <= lb_wdata;
			end
		end
	end

	assign cfg.freq = freq_r;
	assign cfg.amp = amp_r;
	assign cfg.phase_clr = phase_clr_r;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read-back, one cycle after the read strobe
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		rd_mux = '0;
		if (is_tone) begin
			if (field == tone_pkg::FIELD_FREQ) begin
				rd_mux = freq_r[tone_idx];
			end else begin
				rd_mux = {{(32 - `SAMPLE_W){1'b0}}, amp_r[tone_idx]};
			end
		end else if (is_scratch) begin
			rd_mux = scratch;
		end
	end

	always_ff @(posedge dsp) begin
		if (!rst_n) begin
			lb_rvalid <= 1'b0;
		end else begin
			lb_rvalid <= (lb_op == tone_pkg::LB_READ);
		end
	end

	always_ff @(posedge dsp) begin
		if (lb_op == tone_pkg::LB_READ) begin
			lb_rdata <= rd_mux;
		end
	end

	// a restart strobe lasts a single cycle
	for (genvar p = 0; p < `TONE_PAIRS; p++) begin : g_clr_chk
		a_clr_single: assert property (@(posedge dsp) disable iff (!rst_n)
			phase_clr_r[p] |=> !phase_clr_r[p]);
	end

	a_rvalid_follows_read: assert property (@(posedge dsp) disable iff (!rst_n)
		(lb_op == tone_pkg::LB_READ) |=> lb_rvalid);

	a_rvalid_needs_read: assert property (@(posedge dsp) disable iff (!rst_n)
		lb_rvalid |-> $past(lb_op == tone_pkg::LB_READ));

endmodule

// ==== logic/tone_cfg_if.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

interface tone_cfg_if;

	// per-tone phase increment, added to the accumulator every dsp cycle
	logic [`PHASE_W-1:0] freq [`TONE_COUNT];

	// per-tone signed scale, 32767 is close to full scale
	logic signed [`SAMPLE_W-1:0] amp [`TONE_COUNT];

	// one-cycle restart strobe for all tones of a pair
	logic [`TONE_PAIRS-1:0] phase_clr;

	modport regmap (
		output freq,
		output amp,
		output phase_clr
	);

	modport osc (
		input freq,
		input amp,
		input phase_clr
	);

endinterface

// ==== logic/tone_macros.svh ====
`ifndef TONE_MACROS_SVH
`define TONE_MACROS_SVH

// synthesizer size, two DAC pairs with four tones summed into each
`define TONE_PAIRS 2
`define TONES_PER_PAIR 4
`define TONE_COUNT (`TONE_PAIRS * `TONES_PER_PAIR)

// one DAC word carries four copies of the same sample
`define SAMPLE_W 16
`define DAC_W (4 * `SAMPLE_W)

// phase accumulator and table index
`define PHASE_W 32
`define LUT_BITS 6

// local-bus address map
// tone registers sit at 0..15, even is frequency and odd is amplitude
`define ADDR_W 5
`define ADDR_SCRATCH 16

`endif

// ==== logic/tone_pkg.sv ====
`include "tone_macros.svh"

package tone_pkg;

	typedef enum logic [1:0] {
		LB_IDLE  = 2'd0,
		LB_WRITE = 2'd1,
		LB_READ  = 2'd2
	} lb_op_e;

	// address bit 0 picks the field inside one tone
	typedef enum logic {
		FIELD_FREQ = 1'b0,
		FIELD_AMP  = 1'b1
	} reg_field_e;

	// number of table entries in a quarter turn
	localparam int QUARTER = 1 << (`LUT_BITS - 2);

	// first quadrant of round(32767*cos(2*pi*k/64)), k from 0 to 16
	function automatic logic signed [`SAMPLE_W-1:0] cos_quarter(
		input logic [`LUT_BITS-2:0] k
	);
		case (k)
			5'd0: return 16'sd32767;
			5'd1: return 16'sd32609;
			5'd2: return 16'sd32137;
			5'd3: return 16'sd31356;
			5'd4: return 16'sd30273;
			5'd5: return 16'sd28898;
			5'd6: return 16'sd27245;
			5'd7: return 16'sd25329;
			5'd8: return 16'sd23170;
			5'd9: return 16'sd20787;
			5'd10: return 16'sd18204;
			5'd11: return 16'sd15446;
			5'd12: return 16'sd12539;
			5'd13: return 16'sd9512;
			5'd14: return 16'sd6393;
			5'd15: return 16'sd3212;
			default: return 16'sd0;
		endcase
	endfunction

	// the other three quadrants come from mirroring and negating the first
	function automatic logic signed [`SAMPLE_W-1:0] cos_entry(
		input logic [`LUT_BITS-1:0] i
	);
		logic [`LUT_BITS-2:0] k_up;
		logic [`LUT_BITS-2:0] k_dn;
		k_up = {1'b0, i[`LUT_BITS-3:0]};
		k_dn = QUARTER[`LUT_BITS-2:0] - k_up;
		case (i[`LUT_BITS-1 -: 2])
			2'd0: return cos_quarter(k_up);
			2'd1: return -cos_quarter(k_dn);
			2'd2: return -cos_quarter(k_up);
			default: return cos_quarter(k_dn);
		endcase
	endfunction

endpackage

// ==== logic/tone_sum.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module tone_sum (
	input logic dsp,
	input logic rst_n,
	input logic signed [`SAMPLE_W-1:0] tone_x [`TONES_PER_PAIR],
	input logic signed [`SAMPLE_W-1:0] tone_y [`TONES_PER_PAIR],
	output logic [`DAC_W-1:0] dac_x,
	output logic [`DAC_W-1:0] dac_y
);

	localparam int HALF = `TONES_PER_PAIR / 2;
	localparam int LANES = `DAC_W / `SAMPLE_W;

	logic signed [`SAMPLE_W-1:0] part_x_d [2];
	logic signed [`SAMPLE_W-1:0] part_y_d [2];
	logic signed [`SAMPLE_W-1:0] part_x [2];
	logic signed [`SAMPLE_W-1:0] part_y [2];
	logic signed [`SAMPLE_W-1:0] sum_x;
	logic signed [`SAMPLE_W-1:0] sum_y;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 1, two partial sums per channel
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// every add stays 16 bits wide so overflow wraps like the DAC expects
	always_comb begin
		part_x_d[0] = '0;
		part_x_d[1] = '0;
		part_y_d[0] = '0;
		part_y_d[1] = '0;
		for (int j = 0; j < `TONES_PER_PAIR; j++) begin
			if (j < HALF) begin
				part_x_d[0] = part_x_d[0] + tone_x[j];
				part_y_d[0] = part_y_d[0] + tone_y[j];
			end else begin
				part_x_d[1] = part_x_d[1] + tone_x[j];
				part_y_d[1] = part_y_d[1] + tone_y[j];
			end
		end
	end

	always_ff @(posedge dsp) begin
		part_x <= part_x_d;
		part_y <= part_y_d;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stage 2, final sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge dsp) begin
		if (!rst_n) begin
			sum_x <= '0;
			sum_y <= '0;
		end else begin
			sum_x <= part_x[0] + part_x[1];
			sum_y <= part_y[0] + part_y[1];
		end
	end

	// the same sample goes out in every lane of the word
	assign dac_x = {LANES{sum_x}};
	assign dac_y = {LANES{sum_y}};

endmodule

// ==== logic/tone_synth_top.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module tone_synth_top (
	input logic dsp,
	input logic rst_n,
	input tone_pkg::lb_op_e lb_op,
	input logic [`ADDR_W-1:0] lb_addr,
	input logic [31:0] lb_wdata,
	output logic [31:0] lb_rdata,
	output logic lb_rvalid,
	output logic [`DAC_W-1:0] dac0,
	output logic [`DAC_W-1:0] dac1,
	output logic [`DAC_W-1:0] dac2,
	output logic [`DAC_W-1:0] dac3
);

	logic signed [`SAMPLE_W-1:0] tone_x [`TONE_PAIRS][`TONES_PER_PAIR];
	logic signed [`SAMPLE_W-1:0] tone_y [`TONE_PAIRS][`TONES_PER_PAIR];
	logic [`DAC_W-1:0] dac_x [`TONE_PAIRS];
	logic [`DAC_W-1:0] dac_y [`TONE_PAIRS];

	tone_cfg_if cfg_bus ();

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	lb_regmap u_regmap (
		.dsp(dsp),
		.rst_n(rst_n),
		.lb_op(lb_op),
		.lb_addr(lb_addr),
		.lb_wdata(lb_wdata),
		.lb_rdata(lb_rdata),
		.lb_rvalid(lb_rvalid),
		.cfg(cfg_bus)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// oscillator bank
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tones are numbered pair by pair, so tone t belongs to pair t/4
	for (genvar t = 0; t < `TONE_COUNT; t++) begin : g_dlo
		dlo u_dlo (
			.dsp(dsp),
			.rst_n(rst_n),
			.phase_clr(cfg_bus.phase_clr[t / `TONES_PER_PAIR]),
			.freq(cfg_bus.freq[t]),
			.amp(cfg_bus.amp[t]),
			.x(tone_x[t / `TONES_PER_PAIR][t % `TONES_PER_PAIR]),
			.y(tone_y[t / `TONES_PER_PAIR][t % `TONES_PER_PAIR])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-pair summers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar p = 0; p < `TONE_PAIRS; p++) begin : g_sum
		tone_sum u_sum (
			.dsp(dsp),
			.rst_n(rst_n),
			.tone_x(tone_x[p]),
			.tone_y(tone_y[p]),
			.dac_x(dac_x[p]),
			.dac_y(dac_y[p])
		);
	end

	// even DACs carry x and odd DACs carry y
	assign dac0 = dac_x[0];
	assign dac1 = dac_y[0];
	assign dac2 = dac_x[1];
	assign dac3 = dac_y[1];

endmodule

// ==== tb/tone_synth_checks.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module tone_synth_checks (
	input logic dsp,
	input logic rst_n,
	input tone_pkg::lb_op_e lb_op,
	input logic [`ADDR_W-1:0] lb_addr,
	input logic [31:0] lb_wdata,
	input logic [31:0] lb_rdata,
	input logic lb_rvalid,
	input logic [`DAC_W-1:0] dac0,
	input logic [`DAC_W-1:0] dac1,
	input logic [`DAC_W-1:0] dac2,
	input logic [`DAC_W-1:0] dac3,
	input logic [2:0] test_id,
	output int errors
);

	localparam int LANES = `DAC_W / `SAMPLE_W;
	// lookup, scaling, partial sum and final sum after the phase
	localparam int DEPTH = 4;

	logic [`PHASE_W-1:0] freq_m [`TONE_COUNT];
	logic signed [`SAMPLE_W-1:0] amp_m [`TONE_COUNT];
	logic [31:0] scratch_m;
	logic [`TONE_PAIRS-1:0] clr_m;
	logic [`PHASE_W-1:0] ph_m [`TONE_COUNT];
	logic [31:0] rd_exp;
	logic rd_pend;
	logic signed [`SAMPLE_W-1:0] now_x [`TONE_PAIRS];
	logic signed [`SAMPLE_W-1:0] now_y [`TONE_PAIRS];
	logic signed [`SAMPLE_W-1:0] pipe_x [`TONE_PAIRS][DEPTH];
	logic signed [`SAMPLE_W-1:0] pipe_y [`TONE_PAIRS][DEPTH];
	logic [`DAC_W-1:0] exp_x_word [`TONE_PAIRS];
	logic [`DAC_W-1:0] exp_y_word [`TONE_PAIRS];
	logic [`DAC_W-1:0] dac_x_obs [`TONE_PAIRS];
	logic [`DAC_W-1:0] dac_y_obs [`TONE_PAIRS];

	initial errors = 0;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd1: return "reset";
			3'd2: return "readback";
			3'd3: return "single_tone";
			3'd4: return "pair_sum";
			3'd5: return "phase_restart";
			default: return "idle";
		endcase
	endfunction

	// amplitude times table value, then an arithmetic shift right by 15
	function automatic logic signed [`SAMPLE_W-1:0] scaled(
		input logic signed [`SAMPLE_W-1:0] a,
		input logic [`LUT_BITS-1:0] idx
	);
		logic signed [2*`SAMPLE_W-1:0] prod;
		prod = a * tone_pkg::cos_entry(idx);
		return `SAMPLE_W'(prod >>> 15);
	endfunction

	function automatic logic [31:0] read_value(input logic [`ADDR_W-1:0] addr);
		if (addr < `ADDR_W'(2 * `TONE_COUNT)) begin
			if (tone_pkg::reg_field_e'(addr[0]) == tone_pkg::FIELD_FREQ) begin
				return freq_m[addr >> 1];
			end
			return {{(32 - `SAMPLE_W){1'b0}}, amp_m[addr >> 1]};
		end
		if (addr == `ADDR_W'(`ADDR_SCRATCH)) begin
			return scratch_m;
		end
		return '0;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-pair sums for the phases of this cycle, wrapping in 16 bits
	always_comb begin
		for (int p = 0; p < `TONE_PAIRS; p++) begin
			now_x[p] = '0;
			now_y[p] = '0;
		end
		for (int t = 0; t < `TONE_COUNT; t++) begin
			now_x[t / `TONES_PER_PAIR] = now_x[t / `TONES_PER_PAIR]
				+ scaled(amp_m[t], ph_m[t][`PHASE_W-1 -: `LUT_BITS]);
			now_y[t / `TONES_PER_PAIR] = now_y[t / `TONES_PER_PAIR]
				+ scaled(amp_m[t], ph_m[t][`PHASE_W-1 -: `LUT_BITS] - `LUT_BITS'(16));
		end
	end

	always @(posedge dsp) begin
		int tidx;
		tidx = lb_addr >> 1;
		if (!rst_n) begin
			for (int t = 0; t < `TONE_COUNT; t++) begin
				freq_m[t] <= '0;
				amp_m[t] <= '0;
				ph_m[t] <= '0;
			end
			for (int p = 0; p < `TONE_PAIRS; p++) begin
				for (int k = 0; k < DEPTH; k++) begin
					pipe_x[p][k] <= '0;
					pipe_y[p][k] <= '0;
				end
			end
			scratch_m <= '0;
			clr_m <= '0;
			rd_pend <= 1'b0;
		end else begin
			clr_m <= '0;
			rd_pend <= (lb_op == tone_pkg::LB_READ);
			if (lb_op == tone_pkg::LB_READ) begin
				rd_exp <= read_value(lb_addr);
			end
			if (lb_op == tone_pkg::LB_WRITE) begin
				if (lb_addr < `ADDR_W'(2 * `TONE_COUNT)) begin
					if (lb_addr[0] == 1'b0) begin
						freq_m[tidx] <= lb_wdata;
						clr_m[tidx / `TONES_PER_PAIR] <= 1'b1;
					end else begin
						amp_m[tidx] <= lb_wdata[`SAMPLE_W-1:0];
					end
				end else if (lb_addr == `ADDR_W'(`ADDR_SCRATCH)) begin
					scratch_m <= lb_wdata;
				end
			end
			for (int t = 0; t < `TONE_COUNT; t++) begin
				ph_m[t] <= clr_m[t / `TONES_PER_PAIR] ? '0 : ph_m[t] + freq_m[t];
			end
			for (int p = 0; p < `TONE_PAIRS; p++) begin
				pipe_x[p][0] <= now_x[p];
				pipe_y[p][0] <= now_y[p];
				for (int k = 1; k < DEPTH; k++) begin
					pipe_x[p][k] <= pipe_x[p][k-1];
					pipe_y[p][k] <= pipe_y[p][k-1];
				end
			end
		end
	end

	assign dac_x_obs[0] = dac0;
	assign dac_y_obs[0] = dac1;
	assign dac_x_obs[1] = dac2;
	assign dac_y_obs[1] = dac3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks at the top-level ports
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_rvalid: assert property (@(posedge dsp) disable iff (!rst_n) lb_rvalid == rd_pend)
	else begin
		errors++;
		$display("MISMATCH %s: lb_rvalid expected %0b, actual %0b",
			test_name($sampled(test_id)), $sampled(rd_pend), $sampled(lb_rvalid));
	end

	a_rdata: assert property (@(posedge dsp) disable iff (!rst_n)
		lb_rvalid |-> lb_rdata == rd_exp)
	else begin
		errors++;
		$display("MISMATCH %s: lb_rdata expected %h, actual %h",
			test_name($sampled(test_id)), $sampled(rd_exp), $sampled(lb_rdata));
	end

	for (genvar p = 0; p < `TONE_PAIRS; p++) begin : g_dac_chk
		assign exp_x_word[p] = {LANES{pipe_x[p][DEPTH-1]}};
		assign exp_y_word[p] = {LANES{pipe_y[p][DEPTH-1]}};

		a_dac_x: assert property (@(posedge dsp) disable iff (!rst_n)
			dac_x_obs[p] == exp_x_word[p])
		else begin
			errors++;
			$display("MISMATCH %s: dac%0d expected %h, actual %h",
				test_name($sampled(test_id)), 2 * p,
				$sampled(exp_x_word[p]), $sampled(dac_x_obs[p]));
		end

		a_dac_y: assert property (@(posedge dsp) disable iff (!rst_n)
			dac_y_obs[p] == exp_y_word[p])
		else begin
			errors++;
			$display("MISMATCH %s: dac%0d expected %h, actual %h",
				test_name($sampled(test_id)), 2 * p + 1,
				$sampled(exp_y_word[p]), $sampled(dac_y_obs[p]));
		end
	end

endmodule

// ==== tb/tone_synth_tb.sv ====
`timescale 1ns/1ps
`include "tone_macros.svh"

module tone_synth_tb;

	// the tests take a few hundred cycles and the limit leaves ample room
	localparam int CYCLE_LIMIT = 3000;
	localparam int RVALID_WAIT = 8;

	logic dsp;
	logic rst_n;
	tone_pkg::lb_op_e lb_op;
	logic [`ADDR_W-1:0] lb_addr;
	logic [31:0] lb_wdata;
	logic [31:0] lb_rdata;
	logic lb_rvalid;
	logic [`DAC_W-1:0] dac0;
	logic [`DAC_W-1:0] dac1;
	logic [`DAC_W-1:0] dac2;
	logic [`DAC_W-1:0] dac3;
	logic [2:0] test_id;
	int check_errors;
	int bus_errors;
	int cycles;
	integer seed;

	tone_synth_top DUT (
		.dsp(dsp),
		.rst_n(rst_n),
		.lb_op(lb_op),
		.lb_addr(lb_addr),
		.lb_wdata(lb_wdata),
		.lb_rdata(lb_rdata),
		.lb_rvalid(lb_rvalid),
		.dac0(dac0),
		.dac1(dac1),
		.dac2(dac2),
		.dac3(dac3)
	);

	tone_synth_checks u_checks (
		.dsp(dsp),
		.rst_n(rst_n),
		.lb_op(lb_op),
		.lb_addr(lb_addr),
		.lb_wdata(lb_wdata),
		.lb_rdata(lb_rdata),
		.lb_rvalid(lb_rvalid),
		.dac0(dac0),
		.dac1(dac1),
		.dac2(dac2),
		.dac3(dac3),
		.test_id(test_id),
		.errors(check_errors)
	);

	initial dsp = 1'b0;
	always #20 dsp = ~dsp;

	always @(posedge dsp) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic run_cycles(input int n);
		repeat (n) @(negedge dsp);
	endtask

	task automatic write_reg(input logic [`ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge dsp);
		lb_op = tone_pkg::LB_WRITE;
		lb_addr = addr;
		lb_wdata = data;
		@(negedge dsp);
		lb_op = tone_pkg::LB_IDLE;
	endtask

	// the checker compares the returned data, this task only waits for it
	task automatic read_reg(input logic [`ADDR_W-1:0] addr);
		int waited;
		waited = 0;
		@(negedge dsp);
		lb_op = tone_pkg::LB_READ;
		lb_addr = addr;
		@(negedge dsp);
		lb_op = tone_pkg::LB_IDLE;
		while (!lb_rvalid && waited < RVALID_WAIT) begin
			@(negedge dsp);
			waited++;
		end
		if (!lb_rvalid) begin
			bus_errors++;
			$display("read of address %0d got no read data valid pulse", addr);
		end
	endtask

	initial begin
		seed = 32'h0011_b332;
		rst_n = 1'b0;
		lb_op = tone_pkg::LB_IDLE;
		lb_addr = '0;
		lb_wdata = '0;
		test_id = 3'd1;
		bus_errors = 0;
		cycles = 0;

		repeat (2) @(posedge dsp);
		@(negedge dsp);
		rst_n = 1'b1;
		run_cycles(10);

		test_id = 3'd2;
		for (int a = 0; a < 2 * `TONE_COUNT; a++) begin
			if (a % 2 == 0) begin
				write_reg(a, $random(seed));
			end else begin
				write_reg(a, {16'h0, 16'($random(seed))});
			end
		end
		write_reg(`ADDR_SCRATCH, $random(seed));
		for (int a = 0; a <= `ADDR_SCRATCH; a++) begin
			read_reg(a);
		end
		read_reg(`ADDR_SCRATCH + 1);
		read_reg(31);

		// every tone silent, so one tone alone reaches its DAC
		test_id = 3'd3;
		for (int a = 0; a < 2 * `TONE_COUNT; a++) begin
			write_reg(a, 32'h0);
		end
		write_reg(5, {16'h0, 16'($random(seed))});
		write_reg(4, 32'h0);
		run_cycles(8);

		test_id = 3'd4;
		for (int t = 0; t < `TONE_COUNT; t++) begin
			write_reg(2 * t + 1, {16'h0, 16'($random(seed))});
			write_reg(2 * t, $random(seed));
		end
		run_cycles(40);

		test_id = 3'd5;
		write_reg(3, {16'h0, 16'($random(seed))});
		run_cycles(10);
		write_reg(4, $random(seed));
		run_cycles(20);

		$display("closing report: %0d assertion errors, %0d bus errors",
			check_errors, bus_errors);
		if (check_errors + bus_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
